// File: vlog.f
src/uart_pkg.sv
src/uart_rx_ctrl.sv
src/uart_tx_ctrl.sv
src/uart_rx_fifo.sv
src/uart_top.sv
tests/uart_tb.sv

// File: Bender.yml
package:
  name: uart_serial

sources:
  - files:
      - src/uart_pkg.sv
      - src/uart_rx_ctrl.sv
      - src/uart_tx_ctrl.sv
      - src/uart_rx_fifo.sv
      - src/uart_top.sv
  - target: test
    files:
      - tests/uart_tb.sv

// File: tests/uart_tb.sv
module uart_tb;

  localparam int CLKS_PER_BIT = 16;
  localparam int FIFO_DEPTH   = 4;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
  localparam int LOOP_BYTES   = 8;
  localparam int TIMEOUT      = (40 * FRAME_CLKS + 1000) * CLK_PERIOD;

  localparam logic [31:0] LFSR_SEED = 32'h190e_d03f;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                 clock;
  logic                 rst_n;
  logic                 tx_strobe;
  uart_pkg::uart_byte_t tx_byte;
  logic                 tx_busy;
  logic                 tx_serial;
  logic                 rx_serial;
  logic                 rx_pop;
  uart_pkg::uart_byte_t rx_byte;
  logic                 rx_empty;
  logic                 rx_overrun;
  logic                 rx_frame_err;

  logic                 loop_sel;  // 1 ties the receiver to the transmitter
  logic                 rx_drive;
  logic                 overrun_allowed;
  logic                 frame_err_allowed;
  logic [31:0]          lfsr;
  int                   busy_cycles;
  uart_pkg::uart_byte_t tx_expect[$];  // Frames the monitor should see
  uart_pkg::uart_byte_t rx_expect[$];  // Bytes the FIFO should deliver

  assign rx_serial = loop_sel ? tx_serial : rx_drive;

  uart_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) dut_i (
    .i_Clock        (clock),
    .i_rst_n        (rst_n),
    .i_tx_strobe    (tx_strobe),
    .i_tx_byte      (tx_byte),
    .o_tx_busy      (tx_busy),
    .o_tx_serial    (tx_serial),
    .i_rx_serial    (rx_serial),
    .i_rx_pop       (rx_pop),
    .o_rx_byte      (rx_byte),
    .o_rx_empty     (rx_empty),
    .o_rx_overrun   (rx_overrun),
    .o_rx_frame_err (rx_frame_err)
  );

  initial
  begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic end_with_failure;
    begin
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic report_error(input string msg);
    begin
      $display("ERR %0t: %s", $time, msg);
      end_with_failure();
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? LFSR_TAPS : 32'h0);
  endfunction

  // One LFSR step per data bit
  task automatic rand_byte(output uart_pkg::uart_byte_t b);
    begin
      for (int i = 0; i < uart_pkg::DATA_BITS; i++)
      begin
        b[i] = lfsr[0];
        lfsr = lfsr_next(lfsr);
      end
    end
  endtask

  task automatic next_drive;
    begin
      @(posedge clock);
      #2;
    end
  endtask

  task automatic apply_reset;
    begin
      while (tx_busy)
        next_drive();  // Let a running frame finish
      rst_n = 1'b0;
      repeat (RESET_CYCLES) next_drive();
      rst_n = 1'b1;
      next_drive();
    end
  endtask

  task automatic send_byte(input uart_pkg::uart_byte_t b, input logic to_fifo);
    begin
      while (tx_busy)
        next_drive();
      tx_strobe = 1'b1;
      tx_byte   = b;
      tx_expect.push_back(b);
      if (to_fifo)
        rx_expect.push_back(b);
      next_drive();
      tx_strobe = 1'b0;
    end
  endtask

  // Hand-built frame on the receive pin, followed by two idle bit times
  task automatic drive_rx_frame(input uart_pkg::uart_byte_t b, input logic stop_bit);
    begin
      rx_drive = 1'b0;
      repeat (CLKS_PER_BIT) next_drive();
      for (int i = 0; i < uart_pkg::DATA_BITS; i++)
      begin
        rx_drive = b[i];
        repeat (CLKS_PER_BIT) next_drive();
      end
      rx_drive = stop_bit;
      repeat (CLKS_PER_BIT) next_drive();
      rx_drive = 1'b1;
      repeat (2 * CLKS_PER_BIT) next_drive();
    end
  endtask

  task automatic pop_and_check;
    uart_pkg::uart_byte_t exp_byte;
    begin
      @(negedge clock);
      while (rx_empty)
        @(negedge clock);
      assert (rx_expect.size() > 0)
        else report_error("FIFO holds a byte that was never sent");
      exp_byte = rx_expect.pop_front();
      assert (rx_byte == exp_byte)
        else report_error($sformatf("rx byte %h, expected %h", rx_byte, exp_byte));
      next_drive();
      rx_pop = 1'b1;
      next_drive();
      rx_pop = 1'b0;
    end
  endtask

  // Frame monitor, samples each bit middle counted from the start edge
  initial
  begin : frame_monitor
    uart_pkg::uart_byte_t exp_byte;
    forever
    begin
      @(negedge clock);
      if (rst_n && tx_serial === 1'b0)
      begin
        assert (tx_expect.size() > 0)
          else report_error("frame sent without an accepted strobe");
        exp_byte = tx_expect.pop_front();
        repeat (CLKS_PER_BIT / 2) @(negedge clock);
        assert (tx_serial == 1'b0) else report_error("start bit not low at its middle");
        for (int i = 0; i < uart_pkg::DATA_BITS; i++)
        begin
          repeat (CLKS_PER_BIT) @(negedge clock);
          assert (tx_serial == exp_byte[i])
            else report_error($sformatf("tx bit %0d is %b, byte %h", i, tx_serial, exp_byte));
        end
        repeat (CLKS_PER_BIT) @(negedge clock);
        assert (tx_serial == 1'b1) else report_error("stop bit not high at its middle");
      end
    end
  end

  always @(negedge clock)
  begin
    if (tx_busy)
      busy_cycles++;
    else if (busy_cycles != 0)
    begin
      assert (busy_cycles == FRAME_CLKS)
        else report_error($sformatf("busy lasted %0d cycles", busy_cycles));
      busy_cycles = 0;
    end
  end

  a_reset_values: assert property (@(posedge clock) $rose(rst_n) |->
    (tx_serial && !tx_busy && rx_empty && !rx_overrun && !rx_frame_err))
    else report_error("outputs not at their reset values");

  a_tx_start: assert property (@(posedge clock) disable iff (!rst_n)
    (tx_strobe && !tx_busy) |=> (tx_busy && !tx_serial))
    else report_error("accepted strobe did not start a frame");

  a_overrun_sticky: assert property (@(posedge clock) disable iff (!rst_n)
    rx_overrun |=> rx_overrun)
    else report_error("overrun flag cleared without reset");

  a_frame_err_sticky: assert property (@(posedge clock) disable iff (!rst_n)
    rx_frame_err |=> rx_frame_err)
    else report_error("framing flag cleared without reset");

  a_overrun_expected: assert property (@(posedge clock) disable iff (!rst_n)
    $rose(rx_overrun) |-> overrun_allowed)
    else report_error("unexpected overrun");

  a_frame_err_expected: assert property (@(posedge clock) disable iff (!rst_n)
    $rose(rx_frame_err) |-> frame_err_allowed)
    else report_error("unexpected framing error");

  initial
  begin : watchdog
    #(TIMEOUT);
    $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
    end_with_failure();
  end

  initial
  begin : stimulus
    uart_pkg::uart_byte_t b;
    rst_n             = 1'b0;
    tx_strobe         = 1'b0;
    tx_byte           = '0;
    rx_pop            = 1'b0;
    rx_drive          = 1'b1;
    loop_sel          = 1'b0;
    overrun_allowed   = 1'b0;
    frame_err_allowed = 1'b0;
    busy_cycles       = 0;
    lfsr              = LFSR_SEED;
    apply_reset();

    // Single frame, plus a strobe in mid frame that must be ignored
    rand_byte(b);
    send_byte(b, 1'b0);
    repeat (3 * CLKS_PER_BIT) next_drive();
    tx_strobe = 1'b1;
    tx_byte   = ~b;
    next_drive();
    tx_strobe = 1'b0;
    while (tx_busy)
      next_drive();
    repeat (2 * CLKS_PER_BIT) next_drive();
    assert (tx_expect.size() == 0 && rx_empty)
      else report_error("frame count wrong after strobe while busy");

    // Loopback stream, popped as bytes arrive
    loop_sel = 1'b1;
    fork
      repeat (LOOP_BYTES)
      begin
        rand_byte(b);
        send_byte(b, 1'b1);
      end
      repeat (LOOP_BYTES) pop_and_check();
    join
    assert (rx_empty && !rx_overrun) else report_error("FIFO not drained after loopback");

    // One byte more than the FIFO holds
    overrun_allowed = 1'b1;
    for (int i = 0; i <= FIFO_DEPTH; i++)
    begin
      rand_byte(b);
      send_byte(b, i < FIFO_DEPTH);
    end
    while (!rx_overrun)
      next_drive();
    repeat (FIFO_DEPTH) pop_and_check();
    assert (rx_empty && rx_overrun) else report_error("FIFO kept the dropped byte");
    apply_reset();
    overrun_allowed = 1'b0;

    // Low stop bit, then a good frame
    loop_sel          = 1'b0;
    frame_err_allowed = 1'b1;
    rand_byte(b);
    drive_rx_frame(b, 1'b0);
    assert (rx_frame_err && rx_empty) else report_error("low stop bit not handled");
    rand_byte(b);
    rx_expect.push_back(b);
    drive_rx_frame(b, 1'b1);
    pop_and_check();
    apply_reset();
    frame_err_allowed = 1'b0;

    // Glitch shorter than half a bit
    rx_drive = 1'b0;
    repeat (CLKS_PER_BIT / 2 - 2) next_drive();
    rx_drive = 1'b1;
    repeat (3 * CLKS_PER_BIT) next_drive();
    assert (rx_empty && !rx_frame_err) else report_error("glitch produced a byte or error");
    rand_byte(b);
    rx_expect.push_back(b);
    drive_rx_frame(b, 1'b1);
    pop_and_check();
    assert (rx_empty) else report_error("FIFO not empty at the end");

    $display("Verification passed");
    $finish;
  end

endmodule

// File: src/uart_top.sv
module uart_top
#(
  parameter int CLKS_PER_BIT = 16,
  parameter int FIFO_DEPTH   = 4
)
(
  input  logic                 i_Clock,
  input  logic                 i_rst_n,
  input  logic                 i_tx_strobe,
  input  uart_pkg::uart_byte_t i_tx_byte,
  output logic                 o_tx_busy,
  output logic                 o_tx_serial,
  input  logic                 i_rx_serial,
  input  logic                 i_rx_pop,
  output uart_pkg::uart_byte_t o_rx_byte,
  output logic                 o_rx_empty,
  output logic                 o_rx_overrun,
  output logic                 o_rx_frame_err
);

  logic                 rx_dv;
  logic                 rx_frame_err;
  uart_pkg::uart_byte_t rx_data;  // Receiver byte into FIFO

  uart_tx_ctrl #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) tx_ctrl_i (
    .i_Clock     (i_Clock),
    .i_rst_n     (i_rst_n),
    .i_tx_strobe (i_tx_strobe),
    .i_tx_byte   (i_tx_byte),
    .o_tx_serial (o_tx_serial),
    .o_tx_busy   (o_tx_busy)
  );

  uart_rx_ctrl #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) rx_ctrl_i (
    .i_Clock     (i_Clock),
    .i_rst_n     (i_rst_n),
    .i_rx_serial (i_rx_serial),
    .o_rx_dv     (rx_dv),
    .o_frame_err (rx_frame_err),
    .o_rx_byte   (rx_data)
  );

  uart_rx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) rx_fifo_i (
    .i_Clock   (i_Clock),
    .i_rst_n   (i_rst_n),
    .i_wr      (rx_dv),
    .i_rd      (i_rx_pop),
    .i_wr_byte (rx_data),
    .o_rd_byte (o_rx_byte),
    .o_empty   (o_rx_empty),
    .o_overrun (o_rx_overrun)
  );

  // Framing error stays set until reset
  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
      o_rx_frame_err <= 1'b0;
    else if (rx_frame_err)
      o_rx_frame_err <= 1'b1;
  end

endmodule

// File: src/uart_rx_fifo.sv
module uart_rx_fifo
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic                 i_Clock,
  input  logic                 i_rst_n,
  input  logic                 i_wr,
  input  logic                 i_rd,
  input  uart_pkg::uart_byte_t i_wr_byte,
  output uart_pkg::uart_byte_t o_rd_byte,
  output logic                 o_empty,
  output logic                 o_overrun
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(FIFO_DEPTH);

  uart_pkg::uart_byte_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     r_wr_ptr;
  logic [PTR_W-1:0]     r_rd_ptr;
  logic [PTR_W:0]       r_count;  // One extra bit to hold FIFO_DEPTH
  logic                 full;
  logic                 do_wr;
  logic                 do_rd;

  assign full    = (r_count == DEPTH_CNT);
  assign o_empty = (r_count == '0);
  assign do_rd   = i_rd && !o_empty;          // Pop on empty ignored
  assign do_wr   = i_wr && (!full || do_rd);  // Slot frees up on same-cycle pop

  always_ff @(posedge i_Clock)
  begin
    if (do_wr)
      mem[r_wr_ptr] <= i_wr_byte;
  end

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      r_wr_ptr  <= '0;
      r_rd_ptr  <= '0;
      r_count   <= '0;
      o_overrun <= 1'b0;
    end
    else
    begin
      if (do_wr)
        r_wr_ptr <= r_wr_ptr + 1'b1;  // Wraps at power of two
      if (do_rd)
        r_rd_ptr <= r_rd_ptr + 1'b1;

      if (do_wr && !do_rd)
        r_count <= r_count + 1'b1;
      else if (do_rd && !do_wr)
        r_count <= r_count - 1'b1;

      if (i_wr && !do_wr)
        o_overrun <= 1'b1;  // Sticky until reset
    end
  end

  assign o_rd_byte = mem[r_rd_ptr];  // Head shown without a read delay

  a_count_bound: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    r_count <= DEPTH_CNT);

endmodule

// File: src/uart_tx_ctrl.sv
module uart_tx_ctrl
#(
  parameter int CLKS_PER_BIT = 16
)
(
  input  logic                 i_Clock,
  input  logic                 i_rst_n,
  input  logic                 i_tx_strobe,
  input  uart_pkg::uart_byte_t i_tx_byte,
  output logic                 o_tx_serial,
  output logic                 o_tx_busy
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(uart_pkg::DATA_BITS);

  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(uart_pkg::DATA_BITS - 1);

  uart_pkg::tx_state_e  r_state;
  logic [CNT_W-1:0]     r_clk_count;
  logic [IDX_W-1:0]     r_bit_idx;
  uart_pkg::uart_byte_t r_shift;  // Remaining data bits, LSB next

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      r_state     <= uart_pkg::TX_IDLE;
      r_clk_count <= '0;
      r_bit_idx   <= '0;
      o_tx_serial <= 1'b1;
    end
    else
    begin
      case (r_state)
        uart_pkg::TX_IDLE:
        begin
          o_tx_serial <= 1'b1;
          r_clk_count <= '0;
          r_bit_idx   <= '0;
          if (i_tx_strobe)
          begin
            r_shift     <= i_tx_byte;
            o_tx_serial <= 1'b0;  // Start bit begins next cycle
            r_state     <= uart_pkg::TX_START_BIT;
          end
        end

        uart_pkg::TX_START_BIT:
        begin
          if (r_clk_count != FULL_BIT)
            r_clk_count <= r_clk_count + 1'b1;
          else
          begin
            r_clk_count <= '0;
            o_tx_serial <= r_shift[0];
            r_shift     <= r_shift >> 1;
            r_state     <= uart_pkg::TX_DATA_BITS;
          end
        end

        uart_pkg::TX_DATA_BITS:
        begin
          if (r_clk_count != FULL_BIT)
            r_clk_count <= r_clk_count + 1'b1;
          else
          begin
            r_clk_count <= '0;
            if (r_bit_idx == LAST_IDX)
            begin
              r_bit_idx   <= '0;
              o_tx_serial <= 1'b1;  // Stop bit
              r_state     <= uart_pkg::TX_STOP_BIT;
            end
            else
            begin
              r_bit_idx   <= r_bit_idx + 1'b1;
              o_tx_serial <= r_shift[0];
              r_shift     <= r_shift >> 1;
            end
          end
        end

        uart_pkg::TX_STOP_BIT:
        begin
          if (r_clk_count != FULL_BIT)
            r_clk_count <= r_clk_count + 1'b1;
          else
          begin
            r_clk_count <= '0;
            r_state     <= uart_pkg::TX_IDLE;
          end
        end

        default:
          r_state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  assign o_tx_busy = (r_state != uart_pkg::TX_IDLE);  // Covers all ten bit times

  a_idle_high: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    (r_state == uart_pkg::TX_IDLE) |-> o_tx_serial);

endmodule

// File: src/uart_rx_ctrl.sv
module uart_rx_ctrl
#(
  parameter int CLKS_PER_BIT = 16
)
(
  input  logic                i_Clock,
  input  logic                i_rst_n,
  input  logic                i_rx_serial,
  output logic                o_rx_dv,
  output logic                o_frame_err,
  output uart_pkg::uart_byte_t o_rx_byte
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(uart_pkg::DATA_BITS);

  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(uart_pkg::DATA_BITS - 1);

  logic                r_rx_meta;  // First synchronizer stage
  logic                r_rx_data;  // Synchronized line
  uart_pkg::rx_state_e r_state;
  logic [CNT_W-1:0]    r_clk_count;
  logic [IDX_W-1:0]    r_bit_idx;

  // Two flop synchronizer, idles high like the line
  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      r_rx_meta <= 1'b1;
      r_rx_data <= 1'b1;
    end
    else
    begin
      r_rx_meta <= i_rx_serial;
      r_rx_data <= r_rx_meta;
    end
  end

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      r_state     <= uart_pkg::RX_IDLE;
      r_clk_count <= '0;
      r_bit_idx   <= '0;
      o_rx_dv     <= 1'b0;
      o_frame_err <= 1'b0;
    end
    else
    begin
      o_rx_dv     <= 1'b0;  // Strobes default low
      o_frame_err <= 1'b0;

      case (r_state)
        uart_pkg::RX_IDLE:
        begin
          r_clk_count <= '0;
          r_bit_idx   <= '0;
          if (r_rx_data == 1'b0)  // Possible start bit
            r_state <= uart_pkg::RX_START_BIT;
        end

        // Confirm the start bit at its middle
        uart_pkg::RX_START_BIT:
        begin
          if (r_clk_count == HALF_BIT)
          begin
            r_clk_count <= '0;
            if (r_rx_data == 1'b0)
              r_state <= uart_pkg::RX_DATA_BITS;
            else
              r_state <= uart_pkg::RX_IDLE;  // Glitch, drop it
          end
          else
            r_clk_count <= r_clk_count + 1'b1;
        end

        uart_pkg::RX_DATA_BITS:
        begin
          if (r_clk_count != FULL_BIT)
            r_clk_count <= r_clk_count + 1'b1;
          else
          begin
            r_clk_count          <= '0;
            o_rx_byte[r_bit_idx] <= r_rx_data;  // LSB arrives first
            if (r_bit_idx == LAST_IDX)
            begin
              r_bit_idx <= '0;
              r_state   <= uart_pkg::RX_STOP_BIT;
            end
            else
              r_bit_idx <= r_bit_idx + 1'b1;
          end
        end

        // Stop bit sampled at its middle as well
        uart_pkg::RX_STOP_BIT:
        begin
          if (r_clk_count != FULL_BIT)
            r_clk_count <= r_clk_count + 1'b1;
          else
          begin
            r_clk_count <= '0;
            o_rx_dv     <= r_rx_data;
            o_frame_err <= ~r_rx_data;  // Low stop bit
            r_state     <= uart_pkg::RX_CLEANUP;
          end
        end

        uart_pkg::RX_CLEANUP:
          r_state <= uart_pkg::RX_IDLE;  // One cycle gap

        default:
          r_state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // One outcome per frame, never both
  a_dv_err_excl: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    !(o_rx_dv && o_frame_err));

  a_dv_pulse: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    o_rx_dv |=> !o_rx_dv);

  a_err_pulse: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
    o_frame_err |=> !o_frame_err);

endmodule

// File: src/uart_pkg.sv
package uart_pkg;

  // Frame format is fixed at 8N1
  localparam int DATA_BITS = 8;

  typedef logic [DATA_BITS-1:0] uart_byte_t;

  // Receiver FSM
  typedef enum logic [2:0]
  {
    RX_IDLE      = 3'b000,
    RX_START_BIT = 3'b001,
    RX_DATA_BITS = 3'b010,
    RX_STOP_BIT  = 3'b011,
    RX_CLEANUP   = 3'b100
  } rx_state_e;

  // Transmitter FSM
  typedef enum logic [1:0]
  {
    TX_IDLE      = 2'b00,
    TX_START_BIT = 2'b01,
    TX_DATA_BITS = 2'b10,
    TX_STOP_BIT  = 2'b11
  } tx_state_e;

endpackage
